// ==== design/ids_stats_pkg.sv ====
`default_nettype none

package ids_stats_pkg;

   localparam int BYTES_PER_BEAT = 8;
   localparam int FIFO_DEPTH     = 16;           // power of two, pointers wrap
   localparam int FIFO_PTR_W     = $clog2(FIFO_DEPTH);
   localparam int NUM_REC_SRC    = 3;            // record sources into the mux
   localparam int NUM_STAT_REGS  = 3;

   typedef logic [63:0]           beat_data_t;
   typedef logic [2:0]            beat_empty_t;  // unused bytes of an eop beat
   typedef logic [15:0]           byte_cnt_t;
   typedef logic [4:0]            fill_t;        // 0 .. FIFO_DEPTH
   typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
   typedef logic [1:0]            stat_addr_t;
   typedef logic [31:0]           stat_val_t;
   typedef logic [11:0]           apb_addr_t;
   typedef logic [31:0]           apb_data_t;

   typedef enum logic {
      STAT_ADD = 1'b0,  // register += operand
      STAT_MAX = 1'b1   // register = max(register, operand)
   } stat_op_e;

   // register map, APB byte address is index * 4
   localparam stat_addr_t REG_RX_BYTES = 2'd0;  // 0x000
   localparam stat_addr_t REG_TX_PKTS  = 2'd1;  // 0x004
   localparam stat_addr_t REG_MAX_FILL = 2'd2;  // 0x008

endpackage : ids_stats_pkg

`default_nettype wire

// ==== design/eth_rx_monitor.sv ====
`default_nettype none

module eth_rx_monitor (
   input  logic                       clk_i,
   input  logic                       arst_n_i,
   input  ids_stats_pkg::beat_data_t  in_data_i,
   input  ids_stats_pkg::beat_empty_t in_empty_i,
   input  logic                       in_sop_i,
   input  logic                       in_eop_i,
   input  logic                       in_valid_i,
   output logic                       in_ready_o,
   output ids_stats_pkg::beat_data_t  dn_data_o,
   output ids_stats_pkg::beat_empty_t dn_empty_o,
   output logic                       dn_sop_o,
   output logic                       dn_eop_o,
   output logic                       dn_valid_o,
   input  logic                       dn_ready_i,
   output ids_stats_pkg::stat_addr_t  rec_addr_o,
   output ids_stats_pkg::stat_op_e    rec_op_o,
   output ids_stats_pkg::stat_val_t   rec_val_o,
   output logic                       rec_valid_o,
   input  logic                       rec_ready_i
);

   logic                     stall;
   logic                     xfer;
   ids_stats_pkg::byte_cnt_t beat_bytes;
   ids_stats_pkg::byte_cnt_t pkt_bytes;  // length so far, this beat included
   ids_stats_pkg::byte_cnt_t acc_q;
   ids_stats_pkg::byte_cnt_t len_q;      // length of the last finished packet

   assign stall      = in_eop_i & rec_valid_o;  // eop waits for a free record slot
   assign in_ready_o = dn_ready_i & ~stall;
   assign dn_valid_o = in_valid_i & ~stall;
   assign dn_data_o  = in_data_i;
   assign dn_empty_o = in_empty_i;
   assign dn_sop_o   = in_sop_i;
   assign dn_eop_o   = in_eop_i;
   assign xfer       = in_valid_i & in_ready_o;

   assign beat_bytes = ids_stats_pkg::byte_cnt_t'(ids_stats_pkg::BYTES_PER_BEAT)
                     - (in_eop_i ? ids_stats_pkg::byte_cnt_t'(in_empty_i) : '0);
   assign pkt_bytes  = in_sop_i ? beat_bytes : acc_q + beat_bytes;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         acc_q       <= '0;
         rec_valid_o <= 1'b0;
      end else begin
         if (xfer) begin
            acc_q <= pkt_bytes;
         end
         if (xfer && in_eop_i) begin
            rec_valid_o <= 1'b1;
         end else if (rec_ready_i) begin
            rec_valid_o <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (xfer && in_eop_i) begin
         len_q <= pkt_bytes;
      end
   end

   assign rec_addr_o = ids_stats_pkg::REG_RX_BYTES;
   assign rec_op_o   = ids_stats_pkg::STAT_ADD;
   assign rec_val_o  = ids_stats_pkg::stat_val_t'(len_q);

endmodule : eth_rx_monitor

`default_nettype wire

// ==== design/pkt_fifo.sv ====
`default_nettype none

module pkt_fifo (
   input  logic                       clk_i,
   input  logic                       arst_n_i,
   input  ids_stats_pkg::beat_data_t  up_data_i,
   input  ids_stats_pkg::beat_empty_t up_empty_i,
   input  logic                       up_sop_i,
   input  logic                       up_eop_i,
   input  logic                       up_valid_i,
   output logic                       up_ready_o,
   output ids_stats_pkg::beat_data_t  dn_data_o,
   output ids_stats_pkg::beat_empty_t dn_empty_o,
   output logic                       dn_sop_o,
   output logic                       dn_eop_o,
   output logic                       dn_valid_o,
   input  logic                       dn_ready_i,
   output ids_stats_pkg::stat_addr_t  rec_addr_o,
   output ids_stats_pkg::stat_op_e    rec_op_o,
   output ids_stats_pkg::stat_val_t   rec_val_o,
   output logic                       rec_valid_o,
   input  logic                       rec_ready_i
);

   ids_stats_pkg::beat_data_t  data_mem  [ids_stats_pkg::FIFO_DEPTH];
   ids_stats_pkg::beat_empty_t empty_mem [ids_stats_pkg::FIFO_DEPTH];
   logic                       sop_mem   [ids_stats_pkg::FIFO_DEPTH];
   logic                       eop_mem   [ids_stats_pkg::FIFO_DEPTH];

   ids_stats_pkg::fifo_ptr_t   wr_ptr_q, rd_ptr_q;
   ids_stats_pkg::fill_t       count_q, count_nxt;
   ids_stats_pkg::fill_t       peak_q;  // highest fill seen since reset
   logic                       wr, rd;

   assign wr         = up_valid_i & up_ready_o;
   assign rd         = dn_valid_o & dn_ready_i;
   assign count_nxt  = count_q + ids_stats_pkg::fill_t'(wr) - ids_stats_pkg::fill_t'(rd);
   assign dn_valid_o = (count_q != '0);  // a write shows up one cycle later

   assign dn_data_o  = data_mem[rd_ptr_q];
   assign dn_empty_o = empty_mem[rd_ptr_q];
   assign dn_sop_o   = sop_mem[rd_ptr_q];
   assign dn_eop_o   = eop_mem[rd_ptr_q];

   always_ff @(posedge clk_i) begin
      if (wr) begin
         data_mem[wr_ptr_q]  <= up_data_i;
         empty_mem[wr_ptr_q] <= up_empty_i;
         sop_mem[wr_ptr_q]   <= up_sop_i;
         eop_mem[wr_ptr_q]   <= up_eop_i;
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr_q    <= '0;
         rd_ptr_q    <= '0;
         count_q     <= '0;
         up_ready_o  <= 1'b0;  // comes up on the first clock after reset
         peak_q      <= '0;
         rec_valid_o <= 1'b0;
      end else begin
         if (wr) begin
            wr_ptr_q <= wr_ptr_q + ids_stats_pkg::fifo_ptr_t'(1);
         end
         if (rd) begin
            rd_ptr_q <= rd_ptr_q + ids_stats_pkg::fifo_ptr_t'(1);
         end
         count_q    <= count_nxt;
         up_ready_o <= (count_nxt != ids_stats_pkg::fill_t'(ids_stats_pkg::FIFO_DEPTH));
         // a new peak folds into the pending record
         if (count_nxt > peak_q) begin
            peak_q      <= count_nxt;
            rec_valid_o <= 1'b1;
         end else if (rec_ready_i) begin
            rec_valid_o <= 1'b0;
         end
      end
   end

   assign rec_addr_o = ids_stats_pkg::REG_MAX_FILL;
   assign rec_op_o   = ids_stats_pkg::STAT_MAX;
   assign rec_val_o  = ids_stats_pkg::stat_val_t'(peak_q);

endmodule : pkt_fifo

`default_nettype wire

// ==== design/eth_tx_monitor.sv ====
`default_nettype none

module eth_tx_monitor (
   input  logic                       clk_i,
   input  logic                       arst_n_i,
   input  ids_stats_pkg::beat_data_t  up_data_i,
   input  ids_stats_pkg::beat_empty_t up_empty_i,
   input  logic                       up_sop_i,
   input  logic                       up_eop_i,
   input  logic                       up_valid_i,
   output logic                       up_ready_o,
   output ids_stats_pkg::beat_data_t  out_data_o,
   output ids_stats_pkg::beat_empty_t out_empty_o,
   output logic                       out_sop_o,
   output logic                       out_eop_o,
   output logic                       out_valid_o,
   input  logic                       out_ready_i,
   output ids_stats_pkg::stat_addr_t  rec_addr_o,
   output ids_stats_pkg::stat_op_e    rec_op_o,
   output ids_stats_pkg::stat_val_t   rec_val_o,
   output logic                       rec_valid_o,
   input  logic                       rec_ready_i
);

   logic stall;

   assign stall       = up_eop_i & rec_valid_o;  // hold eop until last count is taken
   assign out_valid_o = up_valid_i & ~stall;
   assign up_ready_o  = out_ready_i & ~stall;
   assign out_data_o  = up_data_i;
   assign out_empty_o = up_empty_i;
   assign out_sop_o   = up_sop_i;
   assign out_eop_o   = up_eop_i;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rec_valid_o <= 1'b0;
      end else if (out_valid_o && out_ready_i && up_eop_i) begin
         rec_valid_o <= 1'b1;  // one record per sent packet
      end else if (rec_ready_i) begin
         rec_valid_o <= 1'b0;
      end
   end

   assign rec_addr_o = ids_stats_pkg::REG_TX_PKTS;
   assign rec_op_o   = ids_stats_pkg::STAT_ADD;
   assign rec_val_o  = ids_stats_pkg::stat_val_t'(1);

endmodule : eth_tx_monitor

`default_nettype wire

// ==== design/stats_mux.sv ====
`default_nettype none

module stats_mux (
   input  logic                      clk_i,
   input  logic                      arst_n_i,
   input  ids_stats_pkg::stat_addr_t in0_rec_addr_i,
   input  ids_stats_pkg::stat_op_e   in0_rec_op_i,
   input  ids_stats_pkg::stat_val_t  in0_rec_val_i,
   input  logic                      in0_rec_valid_i,
   output logic                      in0_rec_ready_o,
   input  ids_stats_pkg::stat_addr_t in1_rec_addr_i,
   input  ids_stats_pkg::stat_op_e   in1_rec_op_i,
   input  ids_stats_pkg::stat_val_t  in1_rec_val_i,
   input  logic                      in1_rec_valid_i,
   output logic                      in1_rec_ready_o,
   input  ids_stats_pkg::stat_addr_t in2_rec_addr_i,
   input  ids_stats_pkg::stat_op_e   in2_rec_op_i,
   input  ids_stats_pkg::stat_val_t  in2_rec_val_i,
   input  logic                      in2_rec_valid_i,
   output logic                      in2_rec_ready_o,
   output ids_stats_pkg::stat_addr_t upd_addr_o,
   output ids_stats_pkg::stat_op_e   upd_op_o,
   output ids_stats_pkg::stat_val_t  upd_val_o,
   output logic                      upd_valid_o
);

   ids_stats_pkg::stat_addr_t addr_v [ids_stats_pkg::NUM_REC_SRC];
   ids_stats_pkg::stat_op_e   op_v   [ids_stats_pkg::NUM_REC_SRC];
   ids_stats_pkg::stat_val_t  val_v  [ids_stats_pkg::NUM_REC_SRC];
   logic [ids_stats_pkg::NUM_REC_SRC-1:0] valid_v;
   logic [1:0]                last_q;  // input granted most recently
   logic [1:0]                sel;
   logic                      sel_vld;

   assign addr_v  = '{in0_rec_addr_i, in1_rec_addr_i, in2_rec_addr_i};
   assign op_v    = '{in0_rec_op_i, in1_rec_op_i, in2_rec_op_i};
   assign val_v   = '{in0_rec_val_i, in1_rec_val_i, in2_rec_val_i};
   assign valid_v = {in2_rec_valid_i, in1_rec_valid_i, in0_rec_valid_i};

   // walk from the input after last_q, nearest waiting one wins
   always_comb begin
      int idx;
      sel     = last_q;
      sel_vld = 1'b0;
      for (int k = ids_stats_pkg::NUM_REC_SRC; k >= 1; k--) begin
         idx = (int'(last_q) + k) % ids_stats_pkg::NUM_REC_SRC;
         if (valid_v[idx]) begin
            sel     = 2'(idx);
            sel_vld = 1'b1;
         end
      end
   end

   assign in0_rec_ready_o = sel_vld && (sel == 2'd0);
   assign in1_rec_ready_o = sel_vld && (sel == 2'd1);
   assign in2_rec_ready_o = sel_vld && (sel == 2'd2);

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         last_q      <= '0;
         upd_valid_o <= 1'b0;
      end else begin
         upd_valid_o <= sel_vld;  // bank never stalls
         if (sel_vld) begin
            last_q <= sel;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (sel_vld) begin
         upd_addr_o <= addr_v[sel];
         upd_op_o   <= op_v[sel];
         upd_val_o  <= val_v[sel];
      end
   end

endmodule : stats_mux

`default_nettype wire

// ==== design/stats_regs.sv ====
`default_nettype none

module stats_regs (
   input  logic                      clk_i,
   input  logic                      arst_n_i,
   input  ids_stats_pkg::stat_addr_t upd_addr_i,
   input  ids_stats_pkg::stat_op_e   upd_op_i,
   input  ids_stats_pkg::stat_val_t  upd_val_i,
   input  logic                      upd_valid_i,
   input  logic                      apb_psel_i,
   input  logic                      apb_penable_i,
   input  logic                      apb_pwrite_i,
   input  ids_stats_pkg::apb_addr_t  apb_paddr_i,
   input  ids_stats_pkg::apb_data_t  apb_pwdata_i,
   output ids_stats_pkg::apb_data_t  apb_prdata_o,
   output logic                      apb_pready_o,
   output logic                      apb_pslverr_o
);

   ids_stats_pkg::stat_val_t  regs_q [ids_stats_pkg::NUM_STAT_REGS];
   ids_stats_pkg::stat_addr_t reg_idx;
   ids_stats_pkg::stat_val_t  rd_val;
   logic                      access;
   logic                      mapped;
   logic                      wr_en;

   function automatic ids_stats_pkg::stat_val_t apply_rec(
      input ids_stats_pkg::stat_val_t cur,
      input ids_stats_pkg::stat_op_e  op,
      input ids_stats_pkg::stat_val_t val
   );
      if (op == ids_stats_pkg::STAT_MAX) begin
         return (val > cur) ? val : cur;
      end
      return cur + val;  // counters wrap
   endfunction

   assign access  = apb_psel_i & apb_penable_i;  // access phase
   assign reg_idx = apb_paddr_i[3:2];
   assign mapped  = (apb_paddr_i[11:4] == '0) && (apb_paddr_i[1:0] == 2'b00)
                 && (int'(reg_idx) < ids_stats_pkg::NUM_STAT_REGS);
   assign wr_en   = access & apb_pwrite_i & mapped;

   always_comb begin
      rd_val = '0;
      for (int i = 0; i < ids_stats_pkg::NUM_STAT_REGS; i++) begin
         if (reg_idx == ids_stats_pkg::stat_addr_t'(i)) begin
            rd_val = regs_q[i];
         end
      end
   end

   assign apb_pready_o  = access;  // no wait states
   assign apb_pslverr_o = access & ~mapped;
   assign apb_prdata_o  = (access && !apb_pwrite_i && mapped) ? rd_val : '0;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         for (int i = 0; i < ids_stats_pkg::NUM_STAT_REGS; i++) begin
            regs_q[i] <= '0;
         end
      end else begin
         for (int i = 0; i < ids_stats_pkg::NUM_STAT_REGS; i++) begin
            // software write beats a record to the same register
            if (wr_en && reg_idx == ids_stats_pkg::stat_addr_t'(i)) begin
               regs_q[i] <= apb_pwdata_i;
            end else if (upd_valid_i && upd_addr_i == ids_stats_pkg::stat_addr_t'(i)) begin
               regs_q[i] <= apply_rec(regs_q[i], upd_op_i, upd_val_i);
            end
         end
      end
   end

endmodule : stats_regs

`default_nettype wire

// ==== design/ids_stats_top.sv ====
`default_nettype none

module ids_stats_top (
   input  logic                       clk_i,
   input  logic                       arst_n_i,
   input  ids_stats_pkg::beat_data_t  in_data_i,
   input  ids_stats_pkg::beat_empty_t in_empty_i,
   input  logic                       in_sop_i,
   input  logic                       in_eop_i,
   input  logic                       in_valid_i,
   output logic                       in_ready_o,
   output ids_stats_pkg::beat_data_t  out_data_o,
   output ids_stats_pkg::beat_empty_t out_empty_o,
   output logic                       out_sop_o,
   output logic                       out_eop_o,
   output logic                       out_valid_o,
   input  logic                       out_ready_i,
   input  logic                       apb_psel_i,
   input  logic                       apb_penable_i,
   input  logic                       apb_pwrite_i,
   input  ids_stats_pkg::apb_addr_t   apb_paddr_i,
   input  ids_stats_pkg::apb_data_t   apb_pwdata_i,
   output ids_stats_pkg::apb_data_t   apb_prdata_o,
   output logic                       apb_pready_o,
   output logic                       apb_pslverr_o
);

   // rx monitor -> fifo
   ids_stats_pkg::beat_data_t  rx_data;
   ids_stats_pkg::beat_empty_t rx_empty;
   logic                       rx_sop, rx_eop, rx_valid, rx_ready;

   // fifo -> tx monitor
   ids_stats_pkg::beat_data_t  ff_data;
   ids_stats_pkg::beat_empty_t ff_empty;
   logic                       ff_sop, ff_eop, ff_valid, ff_ready;

   // record streams into the mux
   ids_stats_pkg::stat_addr_t  rx_rec_addr, ff_rec_addr, tx_rec_addr;
   ids_stats_pkg::stat_op_e    rx_rec_op, ff_rec_op, tx_rec_op;
   ids_stats_pkg::stat_val_t   rx_rec_val, ff_rec_val, tx_rec_val;
   logic                       rx_rec_valid, ff_rec_valid, tx_rec_valid;
   logic                       rx_rec_ready, ff_rec_ready, tx_rec_ready;

   // merged updates into the bank
   ids_stats_pkg::stat_addr_t  upd_addr;
   ids_stats_pkg::stat_op_e    upd_op;
   ids_stats_pkg::stat_val_t   upd_val;
   logic                       upd_valid;

   eth_rx_monitor my_rx_mon (
      .clk_i(clk_i), .arst_n_i(arst_n_i),
      .in_data_i(in_data_i), .in_empty_i(in_empty_i), .in_sop_i(in_sop_i),
      .in_eop_i(in_eop_i), .in_valid_i(in_valid_i), .in_ready_o(in_ready_o),
      .dn_data_o(rx_data), .dn_empty_o(rx_empty), .dn_sop_o(rx_sop),
      .dn_eop_o(rx_eop), .dn_valid_o(rx_valid), .dn_ready_i(rx_ready),
      .rec_addr_o(rx_rec_addr), .rec_op_o(rx_rec_op), .rec_val_o(rx_rec_val),
      .rec_valid_o(rx_rec_valid), .rec_ready_i(rx_rec_ready)
   );

   pkt_fifo my_fifo (
      .clk_i(clk_i), .arst_n_i(arst_n_i),
      .up_data_i(rx_data), .up_empty_i(rx_empty), .up_sop_i(rx_sop),
      .up_eop_i(rx_eop), .up_valid_i(rx_valid), .up_ready_o(rx_ready),
      .dn_data_o(ff_data), .dn_empty_o(ff_empty), .dn_sop_o(ff_sop),
      .dn_eop_o(ff_eop), .dn_valid_o(ff_valid), .dn_ready_i(ff_ready),
      .rec_addr_o(ff_rec_addr), .rec_op_o(ff_rec_op), .rec_val_o(ff_rec_val),
      .rec_valid_o(ff_rec_valid), .rec_ready_i(ff_rec_ready)
   );

   eth_tx_monitor my_tx_mon (
      .clk_i(clk_i), .arst_n_i(arst_n_i),
      .up_data_i(ff_data), .up_empty_i(ff_empty), .up_sop_i(ff_sop),
      .up_eop_i(ff_eop), .up_valid_i(ff_valid), .up_ready_o(ff_ready),
      .out_data_o(out_data_o), .out_empty_o(out_empty_o), .out_sop_o(out_sop_o),
      .out_eop_o(out_eop_o), .out_valid_o(out_valid_o), .out_ready_i(out_ready_i),
      .rec_addr_o(tx_rec_addr), .rec_op_o(tx_rec_op), .rec_val_o(tx_rec_val),
      .rec_valid_o(tx_rec_valid), .rec_ready_i(tx_rec_ready)
   );

   stats_mux my_stats_mux (
      .clk_i(clk_i), .arst_n_i(arst_n_i),
      .in0_rec_addr_i(rx_rec_addr), .in0_rec_op_i(rx_rec_op), .in0_rec_val_i(rx_rec_val),
      .in0_rec_valid_i(rx_rec_valid), .in0_rec_ready_o(rx_rec_ready),
      .in1_rec_addr_i(ff_rec_addr), .in1_rec_op_i(ff_rec_op), .in1_rec_val_i(ff_rec_val),
      .in1_rec_valid_i(ff_rec_valid), .in1_rec_ready_o(ff_rec_ready),
      .in2_rec_addr_i(tx_rec_addr), .in2_rec_op_i(tx_rec_op), .in2_rec_val_i(tx_rec_val),
      .in2_rec_valid_i(tx_rec_valid), .in2_rec_ready_o(tx_rec_ready),
      .upd_addr_o(upd_addr), .upd_op_o(upd_op), .upd_val_o(upd_val),
      .upd_valid_o(upd_valid)
   );

   stats_regs my_stats_regs (
      .clk_i(clk_i), .arst_n_i(arst_n_i),
      .upd_addr_i(upd_addr), .upd_op_i(upd_op), .upd_val_i(upd_val),
      .upd_valid_i(upd_valid),
      .apb_psel_i(apb_psel_i), .apb_penable_i(apb_penable_i),
      .apb_pwrite_i(apb_pwrite_i), .apb_paddr_i(apb_paddr_i),
      .apb_pwdata_i(apb_pwdata_i), .apb_prdata_o(apb_prdata_o),
      .apb_pready_o(apb_pready_o), .apb_pslverr_o(apb_pslverr_o)
   );

endmodule : ids_stats_top

`default_nettype wire

// ==== verification/ids_stats_checker.sv ====
`default_nettype none

module ids_stats_checker (
   input logic                       clk_i,
   input logic                       arst_n_i,
   input ids_stats_pkg::beat_data_t  in_data_i,
   input ids_stats_pkg::beat_empty_t in_empty_i,
   input logic                       in_sop_i,
   input logic                       in_eop_i,
   input logic                       in_valid_i,
   input logic                       in_ready_i,
   input ids_stats_pkg::beat_data_t  out_data_i,
   input ids_stats_pkg::beat_empty_t out_empty_i,
   input logic                       out_sop_i,
   input logic                       out_eop_i,
   input logic                       out_valid_i,
   input logic                       out_ready_i,
   input logic                       apb_psel_i,
   input logic                       apb_penable_i,
   input logic                       apb_pready_i
);

   logic assert_fired = 1'b0;  // sticky, polled by the testbench

   // stalled output beat must not move
   out_hold_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_data_i)
         && $stable(out_empty_i) && $stable(out_sop_i) && $stable(out_eop_i))
      else begin
         assert_fired = 1'b1;
         $error("output beat changed while stalled");
      end

   // same rule on the input side
   in_hold_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      in_valid_i && !in_ready_i |=> in_valid_i && $stable(in_data_i)
         && $stable(in_empty_i) && $stable(in_sop_i) && $stable(in_eop_i))
      else begin
         assert_fired = 1'b1;
         $error("input beat changed while stalled");
      end

   apb_ready_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      apb_psel_i && apb_penable_i |-> apb_pready_i)
      else begin
         assert_fired = 1'b1;
         $error("pready low in an access phase");
      end

   rst_out_a: assert property (@(posedge clk_i) !arst_n_i |-> !out_valid_i && !in_ready_i)
      else begin
         assert_fired = 1'b1;
         $error("out_valid_o or in_ready_o high during reset");
      end

endmodule : ids_stats_checker

bind ids_stats_top ids_stats_checker u_chk (
   .clk_i(clk_i), .arst_n_i(arst_n_i),
   .in_data_i(in_data_i), .in_empty_i(in_empty_i), .in_sop_i(in_sop_i),
   .in_eop_i(in_eop_i), .in_valid_i(in_valid_i), .in_ready_i(in_ready_o),
   .out_data_i(out_data_o), .out_empty_i(out_empty_o), .out_sop_i(out_sop_o),
   .out_eop_i(out_eop_o), .out_valid_i(out_valid_o), .out_ready_i(out_ready_i),
   .apb_psel_i(apb_psel_i), .apb_penable_i(apb_penable_i), .apb_pready_i(apb_pready_o)
);

`default_nettype wire

// ==== verification/ids_stats_tb.sv ====
`default_nettype none

module ids_stats_tb;

   localparam int TIMEOUT    = 1000;  // cycles per wait
   localparam int NUM_PKTS   = 40;
   localparam int RDY_RANDOM = 0;
   localparam int RDY_HOLD   = 1;

   logic clk_i, arst_n_i;
   ids_stats_pkg::beat_data_t  in_data_i, out_data_o;
   ids_stats_pkg::beat_empty_t in_empty_i, out_empty_o;
   logic in_sop_i, in_eop_i, in_valid_i, in_ready_o;
   logic out_sop_o, out_eop_o, out_valid_o, out_ready_i;
   logic apb_psel_i, apb_penable_i, apb_pwrite_i, apb_pready_o, apb_pslverr_o;
   ids_stats_pkg::apb_addr_t apb_paddr_i;
   ids_stats_pkg::apb_data_t apb_pwdata_i, apb_prdata_o;

   logic [68:0] exp_q[$];  // {data, empty, sop, eop}
   logic [31:0] pkt_rnd, rdy_rnd;
   logic [31:0] bytes_sent;
   int          pkts_sent, beats_sent, rdy_mode;

   ids_stats_top uut (.*);

   initial begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] st);
      return st * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic ids_stats_pkg::apb_addr_t reg_addr(input ids_stats_pkg::stat_addr_t idx);
      return ids_stats_pkg::apb_addr_t'({idx, 2'b00});  // word aligned
   endfunction

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Regression failed");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string msg);
      abort_run($sformatf("ERR %0t: %s", $time, msg));
   endtask

   // called at a falling edge, returns at the falling edge after the transfer
   task automatic send_beat(input ids_stats_pkg::beat_data_t d,
                            input ids_stats_pkg::beat_empty_t e, input logic s, input logic eo);
      int   waited;
      logic took;
      in_data_i  = d;
      in_empty_i = e;
      in_sop_i   = s;
      in_eop_i   = eo;
      in_valid_i = 1'b1;
      exp_q.push_back({d, e, s, eo});
      waited = 0;
      took   = 1'b0;
      while (!took) begin
         #1;
         took = in_ready_o;  // settled mid cycle
         @(negedge clk_i);
         waited++;
         if (!took && waited > TIMEOUT) abort_run("timeout waiting for in_ready_o");
      end
      in_valid_i = 1'b0;
      beats_sent++;
   endtask

   task automatic send_packet(input int nbeats);
      ids_stats_pkg::beat_data_t  d;
      ids_stats_pkg::beat_empty_t e;
      e = '0;
      for (int b = 0; b < nbeats; b++) begin
         pkt_rnd = lcg_next(pkt_rnd);
         d[63:32] = pkt_rnd;
         pkt_rnd = lcg_next(pkt_rnd);
         d[31:0] = pkt_rnd;
         if (b == nbeats - 1) e = ids_stats_pkg::beat_empty_t'(pkt_rnd[18:16]);
         send_beat(d, e, b == 0, b == nbeats - 1);
      end
      bytes_sent = bytes_sent + 32'(nbeats * ids_stats_pkg::BYTES_PER_BEAT) - 32'(e);
      pkts_sent++;
   endtask

   task automatic apb_access(input logic wr, input ids_stats_pkg::apb_addr_t addr,
                             input ids_stats_pkg::apb_data_t wdata,
                             output ids_stats_pkg::apb_data_t rdata, output logic slverr);
      int   waited;
      logic done;
      apb_psel_i    = 1'b1;  // setup phase
      apb_penable_i = 1'b0;
      apb_pwrite_i  = wr;
      apb_paddr_i   = addr;
      apb_pwdata_i  = wdata;
      @(negedge clk_i);
      apb_penable_i = 1'b1;
      waited = 0;
      done   = 1'b0;
      while (!done) begin
         #1;
         done   = apb_pready_o;
         rdata  = apb_prdata_o;
         slverr = apb_pslverr_o;
         @(negedge clk_i);
         waited++;
         if (!done && waited > TIMEOUT) abort_run("timeout waiting for apb_pready_o");
      end
      apb_psel_i    = 1'b0;
      apb_penable_i = 1'b0;
      apb_pwrite_i  = 1'b0;
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      while (exp_q.size() != 0) begin
         @(negedge clk_i);
         waited++;
         if (waited > TIMEOUT) abort_run("timeout waiting for the output to drain");
      end
      repeat (20) @(negedge clk_i);  // let the last records reach the bank
   endtask

   task automatic release_when_full(input int start);
      int waited;
      waited = 0;
      while (beats_sent < start + ids_stats_pkg::FIFO_DEPTH) begin
         @(negedge clk_i);
         waited++;
         if (waited > TIMEOUT) abort_run("timeout waiting for the FIFO to fill");
      end
      repeat (4) @(negedge clk_i);
      @(posedge clk_i);
      rdy_mode = RDY_RANDOM;
   endtask

   // output side, drives out_ready_i and scores every transfer
   initial begin : score_output
      logic [68:0] got, exp;
      forever begin
         @(negedge clk_i);
         rdy_rnd = lcg_next(rdy_rnd);
         out_ready_i = (rdy_mode == RDY_RANDOM) && (rdy_rnd[31:29] > 3'd2);
         #1;
         if (uut.u_chk.assert_fired) abort_run("a protocol assertion in the checker failed");
         if (out_valid_o && out_ready_i) begin
            got = {out_data_o, out_empty_o, out_sop_o, out_eop_o};
            assert (exp_q.size() != 0) else abort_run("output beat with nothing outstanding");
            exp = exp_q.pop_front();
            assert (got == exp)
               else report_mismatch($sformatf("out beat %h, expected %h", got, exp));
         end
      end
   end

   initial begin : main_flow
      ids_stats_pkg::apb_data_t rdata;
      logic                     slverr;
      int                       start;
      arst_n_i = 1'b1;
      in_data_i = '0;
      in_empty_i = '0;
      in_sop_i = 1'b0;
      in_eop_i = 1'b0;
      in_valid_i = 1'b0;
      out_ready_i = 1'b0;
      apb_psel_i = 1'b0;
      apb_penable_i = 1'b0;
      apb_pwrite_i = 1'b0;
      apb_paddr_i = '0;
      apb_pwdata_i = '0;
      pkt_rnd = 32'he218_ebb7;
      rdy_rnd = lcg_next(32'he218_ebb7);
      bytes_sent = '0;
      pkts_sent = 0;
      beats_sent = 0;
      rdy_mode = RDY_RANDOM;
      #1 arst_n_i = 1'b0;
      repeat (10) @(posedge clk_i);
      @(negedge clk_i);
      arst_n_i = 1'b1;

      for (int p = 0; p < NUM_PKTS; p++) begin
         pkt_rnd = lcg_next(pkt_rnd);
         send_packet(1 + int'(pkt_rnd[30:16]) % 6);
      end
      wait_drain();
      apb_access(1'b0, reg_addr(ids_stats_pkg::REG_RX_BYTES), '0, rdata, slverr);
      assert (rdata == bytes_sent && !slverr)
         else report_mismatch($sformatf("rx bytes %0d, expected %0d", rdata, bytes_sent));
      apb_access(1'b0, reg_addr(ids_stats_pkg::REG_TX_PKTS), '0, rdata, slverr);
      assert (rdata == 32'(pkts_sent) && !slverr)
         else report_mismatch($sformatf("tx packets %0d, expected %0d", rdata, pkts_sent));

      // fill the FIFO behind a stalled output
      rdy_mode = RDY_HOLD;
      start = beats_sent;
      fork
         for (int p = 0; p < 20; p++) send_packet(1);
         release_when_full(start);
      join
      wait_drain();
      apb_access(1'b0, reg_addr(ids_stats_pkg::REG_MAX_FILL), '0, rdata, slverr);
      assert (rdata == 32'(ids_stats_pkg::FIFO_DEPTH) && !slverr)
         else report_mismatch($sformatf("max fill %0d, expected %0d", rdata,
                                        ids_stats_pkg::FIFO_DEPTH));

      apb_access(1'b1, reg_addr(ids_stats_pkg::REG_TX_PKTS), 32'ha5a5_0f0f, rdata, slverr);
      apb_access(1'b0, reg_addr(ids_stats_pkg::REG_TX_PKTS), '0, rdata, slverr);
      assert (rdata == 32'ha5a5_0f0f && !slverr)
         else report_mismatch($sformatf("tx packets readback %h, expected a5a50f0f", rdata));
      apb_access(1'b0, 12'h00c, '0, rdata, slverr);  // unmapped
      assert (rdata == '0 && slverr)
         else report_mismatch($sformatf("addr 0x00c read %h, pslverr %b", rdata, slverr));

      if (uut.u_chk.assert_fired) begin
         abort_run("a protocol assertion in the checker failed");
      end else begin
         $display("Regression passed");
         $finish;
      end
   end

endmodule : ids_stats_tb

`default_nettype wire

// ==== compile.f ====
design/ids_stats_pkg.sv
design/eth_rx_monitor.sv
design/pkt_fifo.sv
design/eth_tx_monitor.sv
design/stats_mux.sv
design/stats_regs.sv
design/ids_stats_top.sv
verification/ids_stats_checker.sv
verification/ids_stats_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module ids_stats_tb -f compile.f -o ids_stats_sim
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

out=$(./obj_dir/ids_stats_sim +verilator+error+limit+100)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "^Regression passed$"; then
   exit 0
fi
exit 1
